//--- list.f
+incdir+src
src/obi_pkg.sv
src/wb_pkg.sv
src/obi_wb_bridge.sv
src/wb_intercon.sv
src/wb_sram.sv
src/wb_gpio.sv
src/obi_wb_soc.sv
verification/obi_wb_checker.sv
verification/obi_wb_soc_tb.sv

//--- verification/obi_wb_soc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module obi_wb_soc_tb
    import obi_pkg::*;
    import wb_pkg::*;
();

    localparam int        N_OPS      = 300;    // Upper bound on bus operations in the run
    localparam int        MAX_CYCLES = N_OPS * (`SRAM_WAIT_DEFAULT + 8) + 200;
    localparam obi_addr_t GPIO_OUT_A = {`GPIO_BASE_WADDR, 2'b00};
    localparam obi_addr_t GPIO_IN_A  = GPIO_OUT_A + 32'd4;
    localparam obi_addr_t UNMAP_A    = 32'h0000_2000;  // Outside both windows

    logic        obi_clk = 1'b0;                // Starts low so no edge shows at time zero
    logic        soc_rst_n;
    logic        obi_req;
    logic        obi_gnt;
    obi_addr_t   obi_addr;
    logic        obi_wr_en;
    obi_be_t     obi_byte_en;
    obi_data_t   obi_wdata;
    logic        obi_rvalid;
    obi_data_t   obi_rdata;
    gpio_t       gpio_in;
    gpio_t       gpio_out;
    obi_data_t   sram_model [`SRAM_DEPTH];      // Reference SRAM contents
    gpio_t       gpio_out_model;                // Shadow of GPIO_OUT
    logic [31:0] lfsr;
    obi_addr_t   cur_addr;                      // Operation in flight, seen by the comparator
    logic        cur_is_read;
    obi_data_t   exp_rdata;
    int          req_count;
    int          gnt_count;
    int          rvalid_count;
    int          mismatch_count;
    int          fail_count;
    int          cycle_count;

    obi_wb_soc obi_wb_soc_inst (
        .obi_clk_i(obi_clk), .soc_rst_ni(soc_rst_n),
        .obi_req_i(obi_req), .obi_gnt_o(obi_gnt), .obi_addr_i(obi_addr),
        .obi_wr_en_i(obi_wr_en), .obi_byte_en_i(obi_byte_en), .obi_wdata_i(obi_wdata),
        .obi_rvalid_o(obi_rvalid), .obi_rdata_o(obi_rdata),
        .gpio_i(gpio_in), .gpio_o(gpio_out)
    );

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);             // One step per bit taken
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic obi_data_t expected_rdata(input obi_addr_t a, input gpio_t pins);
        wb_addr_t  w;
        obi_data_t r;
        w = a[31:2];
        if (w < `SRAM_DEPTH) begin
            r = sram_model[w[3:0]];
        end else if (w == `GPIO_BASE_WADDR) begin
            r = obi_data_t'(gpio_out_model);    // Zero-extended pins
        end else if (w == `GPIO_BASE_WADDR + 1) begin
            r = obi_data_t'(pins);
        end else begin
            r = `UNMAPPED_RDATA;
        end
        return r;
    endfunction

    function automatic void update_model(input obi_addr_t a, input obi_be_t be,
                                         input obi_data_t d);
        wb_addr_t w;
        w = a[31:2];
        if (w < `SRAM_DEPTH) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    sram_model[w[3:0]][8*b +: 8] = d[8*b +: 8];
                end
            end
        end else if (w == `GPIO_BASE_WADDR && be[0]) begin
            gpio_out_model = d[`GPIO_W-1:0];    // Only byte 0 reaches the pins
        end
    endfunction

    task automatic bus_cycle(input logic wr, input obi_addr_t a, input obi_be_t be,
                             input obi_data_t d);
        @(posedge obi_clk);
        #1;
        cur_addr    = a;
        cur_is_read = !wr;
        obi_req     = 1'b1;
        obi_addr    = a;
        obi_wr_en   = wr;
        obi_byte_en = be;
        obi_wdata   = d;
        req_count++;
        do begin
            @(negedge obi_clk);
        end while (!obi_gnt);
        @(posedge obi_clk);                     // Grant taken on this edge
        #1;
        obi_req = 1'b0;
        do begin
            @(negedge obi_clk);
        end while (!obi_rvalid);
        #1;                                     // Lets the counters settle first
        if (wr) begin
            update_model(a, be, d);
        end
        if (gnt_count != req_count || rvalid_count != req_count) begin
            $display("request %0d saw %0d grants and %0d rvalid pulses",
                     req_count, gnt_count, rvalid_count);
            fail_count++;
        end
        if (gpio_out !== gpio_out_model) begin
            $display("mismatch: gpio_o got %h expected %h", gpio_out, gpio_out_model);
            mismatch_count++;
        end
    endtask

    task automatic obi_write(input obi_addr_t a, input obi_be_t be, input obi_data_t d);
        bus_cycle(1'b1, a, be, d);
    endtask

    task automatic obi_read(input obi_addr_t a);
        bus_cycle(1'b0, a, 4'hF, '0);
    endtask

    initial begin
        forever #5 obi_clk = ~obi_clk;
    end

    // Grant and rvalid pulses, counted mid-cycle
    always @(negedge obi_clk) begin
        if (obi_gnt) begin
            gnt_count++;
        end
        if (obi_rvalid) begin
            rvalid_count++;
        end
    end

    // Every rvalid carries read data or zero for a write
    always @(negedge obi_clk) begin
        if (soc_rst_n && obi_rvalid) begin
            exp_rdata = cur_is_read ? expected_rdata(cur_addr, gpio_in) : '0;
            if (obi_rdata !== exp_rdata) begin
                $display("mismatch: obi_rdata_o at %h got %h expected %h",
                         cur_addr, obi_rdata, exp_rdata);
                mismatch_count++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge obi_clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a handshake never completed", cycle_count);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [1:0] kind;
        logic       wr;
        obi_addr_t  a;
        obi_be_t    be;
        obi_data_t  d;
        lfsr           = 32'h6121_98ca;
        soc_rst_n      = 1'b0;
        obi_req        = 1'b1;                  // Held high to show reset blocks the grant
        obi_addr       = GPIO_OUT_A;
        obi_wr_en      = 1'b1;
        obi_byte_en    = 4'hF;
        obi_wdata      = 32'hFFFF_FFFF;
        gpio_in        = '0;
        gpio_out_model = '0;
        cur_addr       = '0;
        cur_is_read    = 1'b0;
        {req_count, gnt_count, rvalid_count, mismatch_count, fail_count} = '0;
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            sram_model[i] = '0;
        end
        repeat (8) begin
            @(negedge obi_clk);
            if (obi_gnt !== 1'b0 || obi_rvalid !== 1'b0) begin
                $display("gnt or rvalid went high during reset");
                fail_count++;
            end
        end
        @(posedge obi_clk);
        #1;
        soc_rst_n = 1'b1;
        obi_req   = 1'b0;
        obi_wr_en = 1'b0;
        @(negedge obi_clk);
        if (gpio_out !== '0) begin
            $display("mismatch: gpio_o got %h expected %h", gpio_out, 8'h00);
            mismatch_count++;
        end
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            d = rand_bits(32);
            obi_write(i * 4, 4'hF, d);          // Full words everywhere
        end
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            obi_read(i * 4);
        end
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            a  = rand_bits(4) << 2;
            be = obi_be_t'(rand_bits(4));
            d  = rand_bits(32);
            obi_write(a, be, d);
        end
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            obi_read(i * 4);
        end
        obi_write(GPIO_OUT_A, 4'h1, 32'h0000_00A5);
        obi_read(GPIO_OUT_A);
        obi_write(GPIO_OUT_A, 4'hE, 32'h0000_005A); // Byte 0 off, pins unchanged
        obi_read(GPIO_OUT_A);
        @(posedge obi_clk);
        #1;
        gpio_in = 8'h3C;
        repeat (3) @(posedge obi_clk);          // Through the synchronizer
        obi_read(GPIO_IN_A);
        obi_read(UNMAP_A);
        obi_write(32'h0000_0040, 4'hF, 32'h1234_5678);  // Word 16 lies just past the SRAM
        obi_write(UNMAP_A, 4'hF, 32'h0000_00FF);
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            obi_read(i * 4);
        end
        for (int n = 0; n < 200; n++) begin
            if (n % 50 == 25) begin
                @(posedge obi_clk);
                #1;
                gpio_in = gpio_t'(rand_bits(8));
                repeat (3) @(posedge obi_clk);
            end
            kind = 2'(rand_bits(2));
            wr   = 1'(rand_bits(1));
            be   = obi_be_t'(rand_bits(4));
            d    = rand_bits(32);
            case (kind)
                2'd2: a = GPIO_OUT_A + (rand_bits(1) << 2);
                2'd3: a = (32'h10 + rand_bits(8)) << 2;   // Words 0x10 to 0x10F
                default: a = rand_bits(4) << 2;
            endcase
            if (wr) begin
                obi_write(a, be, d);
            end else begin
                obi_read(a);
            end
        end
        repeat (2) @(posedge obi_clk);
        $display("errors: %0d mismatches, %0d other failures, %0d requests",
                 mismatch_count, fail_count, req_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/obi_wb_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module obi_wb_checker
    import wb_pkg::*;
(
    input  wire         obi_clk_i,
    input  wire         soc_rst_ni,
    input  wire         obi_gnt_i,
    input  wire         obi_rvalid_i,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_ack_i,
    input  wb_addr_t    wb_addr_i,
    input  wb_data_t    wb_wdata_i,
    input  wire         wb_we_i,
    input  wb_sel_t     wb_sel_i
);

    logic pending;                          // A granted request has not seen rvalid yet

    always_ff @(posedge obi_clk_i or negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            pending <= 1'b0;
        end else if (obi_gnt_i) begin
            pending <= 1'b1;
        end else if (obi_rvalid_i) begin
            pending <= 1'b0;                // Transaction closed
        end
    end

    cyc_eq_stb: assert property (@(posedge obi_clk_i) disable iff (!soc_rst_ni)
        wb_cyc_i == wb_stb_i) else $error("wb_cyc_o and wb_stb_o differ");

    // A stalled classic cycle keeps its strobe and payload
    stall_stable: assert property (@(posedge obi_clk_i) disable iff (!soc_rst_ni)
        (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_addr_i) && $stable(wb_wdata_i)
        && $stable(wb_we_i) && $stable(wb_sel_i))) else $error("Wishbone payload moved");

    gnt_pulse: assert property (@(posedge obi_clk_i) disable iff (!soc_rst_ni)
        obi_gnt_i |=> !obi_gnt_i) else $error("gnt longer than one cycle");

    gnt_single: assert property (@(posedge obi_clk_i) disable iff (!soc_rst_ni)
        obi_gnt_i |-> !pending) else $error("second gnt before rvalid");

    rvalid_after_gnt: assert property (@(posedge obi_clk_i) disable iff (!soc_rst_ni)
        obi_rvalid_i |-> pending) else $error("rvalid without a prior gnt");

    quiet_in_reset: assert property (@(posedge obi_clk_i)
        !soc_rst_ni |-> (!obi_gnt_i && !obi_rvalid_i)) else $error("handshake active in reset");

endmodule

bind obi_wb_bridge obi_wb_checker obi_wb_checker_inst (
    .obi_clk_i(obi_clk_i), .soc_rst_ni(soc_rst_ni),
    .obi_gnt_i(obi_gnt_o), .obi_rvalid_i(obi_rvalid_o),
    .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_ack_i(wb_ack_i),
    .wb_addr_i(wb_addr_o), .wb_wdata_i(wb_wdata_o), .wb_we_i(wb_we_o), .wb_sel_i(wb_sel_o)
);

`default_nettype wire

//--- src/obi_wb_soc.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module obi_wb_soc
    import obi_pkg::*;
    import wb_pkg::*;
(
    input  wire         obi_clk_i,
    input  wire         soc_rst_ni,
    input  wire         obi_req_i,
    output logic        obi_gnt_o,
    input  obi_addr_t   obi_addr_i,
    input  wire         obi_wr_en_i,
    input  obi_be_t     obi_byte_en_i,
    input  obi_data_t   obi_wdata_i,
    output logic        obi_rvalid_o,
    output obi_data_t   obi_rdata_o,
    input  gpio_t       gpio_i,
    output gpio_t       gpio_o
);

    logic       wb_cyc;     // Bridge to interconnect, shared by the slaves
    logic       wb_stb;
    wb_addr_t   wb_addr;
    wb_data_t   wb_wdata;
    logic       wb_we;
    wb_sel_t    wb_sel;
    logic       wb_ack;
    wb_data_t   wb_rdata;
    logic       stb_sram;   // Per-slave strobe and response
    logic       ack_sram;
    wb_data_t   rdata_sram;
    logic       stb_gpio;
    logic       ack_gpio;
    wb_data_t   rdata_gpio;

    obi_wb_bridge obi_wb_bridge_inst (
        .obi_clk_i(obi_clk_i), .soc_rst_ni(soc_rst_ni),
        .obi_req_i(obi_req_i), .obi_gnt_o(obi_gnt_o), .obi_addr_i(obi_addr_i),
        .obi_wr_en_i(obi_wr_en_i), .obi_byte_en_i(obi_byte_en_i),
        .obi_wdata_i(obi_wdata_i), .obi_rvalid_o(obi_rvalid_o), .obi_rdata_o(obi_rdata_o),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_addr_o(wb_addr), .wb_wdata_o(wb_wdata),
        .wb_we_o(wb_we), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack), .wb_rdata_i(wb_rdata)
    );

    wb_intercon wb_intercon_inst (
        .obi_clk_i(obi_clk_i), .soc_rst_ni(soc_rst_ni),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_addr_i(wb_addr), .wb_we_i(wb_we),
        .wb_ack_o(wb_ack), .wb_rdata_o(wb_rdata),
        .wb_stb_sram_o(stb_sram), .wb_stb_gpio_o(stb_gpio),
        .wb_ack_sram_i(ack_sram), .wb_rdata_sram_i(rdata_sram),
        .wb_ack_gpio_i(ack_gpio), .wb_rdata_gpio_i(rdata_gpio)
    );

    wb_sram #(.WAIT_CYCLES(`SRAM_WAIT_DEFAULT)) wb_sram_inst (
        .obi_clk_i(obi_clk_i), .soc_rst_ni(soc_rst_ni),
        .wb_cyc_i(wb_cyc), .wb_stb_i(stb_sram), .wb_addr_i(wb_addr),
        .wb_wdata_i(wb_wdata), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
        .wb_ack_o(ack_sram), .wb_rdata_o(rdata_sram)
    );

    wb_gpio wb_gpio_inst (
        .obi_clk_i(obi_clk_i), .soc_rst_ni(soc_rst_ni),
        .wb_cyc_i(wb_cyc), .wb_stb_i(stb_gpio), .wb_addr_i(wb_addr),
        .wb_wdata_i(wb_wdata), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
        .wb_ack_o(ack_gpio), .wb_rdata_o(rdata_gpio),
        .gpio_i(gpio_i), .gpio_o(gpio_o)
    );

endmodule

`default_nettype wire

//--- src/wb_gpio.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module wb_gpio
    import wb_pkg::*;
(
    input  wire         obi_clk_i,
    input  wire         soc_rst_ni,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wb_addr_t    wb_addr_i,
    input  wb_data_t    wb_wdata_i,
    input  wire         wb_we_i,
    input  wb_sel_t     wb_sel_i,
    output logic        wb_ack_o,
    output wb_data_t    wb_rdata_o,
    input  gpio_t       gpio_i,         // Asynchronous pins
    output gpio_t       gpio_o
);

    gpio_t  gpio_meta;                  // First synchronizer stage
    gpio_t  gpio_in_q;                  // GPIO_IN register
    logic   take;                       // Edge that raises ack
    logic   sel_in;                     // Offset 1 addresses GPIO_IN

    assign sel_in = wb_addr_i[0];
    assign take   = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_ff @(posedge obi_clk_i or negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            wb_ack_o  <= 1'b0;
            gpio_o    <= '0;
            gpio_meta <= '0;
            gpio_in_q <= '0;
        end else begin
            wb_ack_o  <= take;          // Ack in the second strobe cycle
            gpio_meta <= gpio_i;
            gpio_in_q <= gpio_meta;
            // GPIO_IN ignores writes
            if (take && wb_we_i && !sel_in && wb_sel_i[0]) begin
                gpio_o <= wb_wdata_i[`GPIO_W-1:0];
            end
        end
    end

    always_comb begin
        wb_rdata_o = '0;
        if (wb_ack_o && !wb_we_i) begin
            // Upper bits stay zero
            wb_rdata_o[`GPIO_W-1:0] = sel_in ? gpio_in_q : gpio_o;
        end
    end

endmodule

`default_nettype wire

//--- src/wb_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module wb_sram
    import wb_pkg::*;
#(
    parameter int unsigned WAIT_CYCLES = `SRAM_WAIT_DEFAULT    // 0 to 7
) (
    input  wire         obi_clk_i,
    input  wire         soc_rst_ni,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wb_addr_t    wb_addr_i,
    input  wb_data_t    wb_wdata_i,
    input  wire         wb_we_i,
    input  wb_sel_t     wb_sel_i,
    output logic        wb_ack_o,
    output wb_data_t    wb_rdata_o
);

    localparam int AW = $clog2(`SRAM_DEPTH);    // Word index width

    wb_data_t           mem [`SRAM_DEPTH];
    logic [2:0]         wait_cnt;               // Strobe cycles seen so far
    logic               ready;                  // Counter has reached the wait count
    logic [AW-1:0]      idx;

    assign idx   = wb_addr_i[AW-1:0];
    assign ready = wb_cyc_i && wb_stb_i && !wb_ack_o && (wait_cnt == 3'(WAIT_CYCLES));

    always_ff @(posedge obi_clk_i or negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            wait_cnt <= '0;
            wb_ack_o <= 1'b0;
        end else begin
            if (!(wb_cyc_i && wb_stb_i) || wb_ack_o) begin
                wait_cnt <= '0;                 // Restart for the next cycle
            end else if (wait_cnt != 3'(WAIT_CYCLES)) begin
                wait_cnt <= wait_cnt + 3'd1;
            end
            wb_ack_o <= ready;                  // Single-cycle acknowledge
        end
    end

    // The write lands on the edge that raises ack
    always_ff @(posedge obi_clk_i) begin
        if (ready && wb_we_i) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
                if (wb_sel_i[b]) begin
                    mem[idx][8*b +: 8] <= wb_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data only while ack is up
    assign wb_rdata_o = (wb_ack_o && !wb_we_i) ? mem[idx] : '0;

endmodule

`default_nettype wire

//--- src/wb_intercon.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module wb_intercon
    import wb_pkg::*;
(
    input  wire         obi_clk_i,
    input  wire         soc_rst_ni,

    input  wire         wb_cyc_i,           // From the bridge
    input  wire         wb_stb_i,
    input  wb_addr_t    wb_addr_i,
    input  wire         wb_we_i,
    output logic        wb_ack_o,           // Back to the bridge
    output wb_data_t    wb_rdata_o,

    output logic        wb_stb_sram_o,      // Per-slave strobes
    output logic        wb_stb_gpio_o,
    input  wire         wb_ack_sram_i,
    input  wb_data_t    wb_rdata_sram_i,
    input  wire         wb_ack_gpio_i,
    input  wb_data_t    wb_rdata_gpio_i
);

    wb_slave_e  slave;
    wb_addr_t   sram_off;                   // Offset into the SRAM window
    wb_addr_t   gpio_off;                   // Offset into the GPIO window
    logic       active;
    logic       none_ack;                   // Unmapped responder flop

    assign sram_off = wb_addr_i - wb_addr_t'(`SRAM_BASE_WADDR);
    assign gpio_off = wb_addr_i - wb_addr_t'(`GPIO_BASE_WADDR);

    always_comb begin
        if (sram_off < wb_addr_t'(`SRAM_DEPTH)) begin
            slave = SLV_SRAM;
        end else if (gpio_off < wb_addr_t'(2)) begin
            slave = SLV_GPIO;                // GPIO_OUT and GPIO_IN
        end else begin
            slave = SLV_NONE;
        end
    end

    assign active        = wb_cyc_i && wb_stb_i;
    assign wb_stb_sram_o = active && (slave == SLV_SRAM);
    assign wb_stb_gpio_o = active && (slave == SLV_GPIO);

    // Acks unmapped cycles in their second cycle, then drops with the strobe
    always_ff @(posedge obi_clk_i or negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= active && (slave == SLV_NONE) && !none_ack;
        end
    end

    always_comb begin
        case (slave)
            SLV_SRAM: begin
                wb_ack_o   = wb_ack_sram_i;
                wb_rdata_o = wb_rdata_sram_i;
            end
            SLV_GPIO: begin
                wb_ack_o   = wb_ack_gpio_i;
                wb_rdata_o = wb_rdata_gpio_i;
            end
            default: begin
                wb_ack_o   = none_ack;
                wb_rdata_o = (none_ack && !wb_we_i) ? wb_data_t'(`UNMAPPED_RDATA) : '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/obi_wb_bridge.sv
`timescale 1ns/1ns
`default_nettype none

`include "bridge_consts.svh"

module obi_wb_bridge
    import obi_pkg::*;
    import wb_pkg::*;
(
    input  wire         obi_clk_i,      // Single clock for both bus sides
    input  wire         soc_rst_ni,     // Asynchronous active-low reset

    input  wire         obi_req_i,      // Master request, payload valid while high
    output logic        obi_gnt_o,      // One-cycle grant
    input  obi_addr_t   obi_addr_i,     // Byte address
    input  wire         obi_wr_en_i,    // High for a write
    input  obi_be_t     obi_byte_en_i,  // Byte enables
    input  obi_data_t   obi_wdata_i,    // Write data
    output logic        obi_rvalid_o,   // One-cycle end-of-transaction pulse
    output obi_data_t   obi_rdata_o,    // Read data, zero after a write

    output logic        wb_cyc_o,       // Cycle, rises and falls with stb
    output logic        wb_stb_o,       // Strobe
    output wb_addr_t    wb_addr_o,      // Word address
    output wb_data_t    wb_wdata_o,     // Write data
    output logic        wb_we_o,        // Write enable
    output wb_sel_t     wb_sel_o,       // Byte select
    input  wire         wb_ack_i,       // Slave acknowledge
    input  wb_data_t    wb_rdata_i      // Slave read data
);

    obi_state_e obi_state;
    obi_state_e obi_state_nxt;
    wb_state_e  wb_state;
    logic       accept;                 // Request taken on this edge
    logic       wb_done;                // Acknowledge taken on this edge

    // A request is only taken when both machines are idle
    assign accept  = obi_req_i && (obi_state == OBI_IDLE) && (wb_state == WB_IDLE);
    assign wb_done = (wb_state == WB_AWAIT) && wb_ack_i;

    always_ff @(posedge obi_clk_i or negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            obi_state <= OBI_IDLE;
        end else begin
            obi_state <= obi_state_nxt;
        end
    end

    always_comb begin
        obi_state_nxt = obi_state;              // Hold by default
        case (obi_state)
            OBI_IDLE: begin
                if (accept) begin
                    obi_state_nxt = OBI_GNT;    // Grant shows in the next cycle
                end
            end
            OBI_GNT: begin
                obi_state_nxt = wb_done ? OBI_VALID : OBI_AWAIT;
            end
            OBI_AWAIT: begin
                if (wb_done) begin
                    obi_state_nxt = OBI_VALID;  // Slave may stall here for any time
                end
            end
            OBI_VALID: begin
                obi_state_nxt = OBI_IDLE;       // rvalid lasts one cycle
            end
            default: begin
                obi_state_nxt = OBI_IDLE;
            end
        endcase
    end

    assign obi_gnt_o    = (obi_state == OBI_GNT);   // Decoded straight from the state
    assign obi_rvalid_o = (obi_state == OBI_VALID);

    // Wishbone control, opened on accept and closed on the acknowledge
    always_ff @(posedge obi_clk_i or negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            wb_state <= WB_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
            wb_sel_o <= '0;
        end else begin
            case (wb_state)
                WB_IDLE: begin
                    if (accept) begin
                        wb_state <= WB_AWAIT;
                        wb_cyc_o <= 1'b1;           // cyc and stb rise together
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= obi_wr_en_i;
                        wb_sel_o <= obi_byte_en_i;
                    end
                end
                WB_AWAIT: begin
                    if (wb_ack_i) begin
                        wb_state <= WB_ACK;
                        wb_cyc_o <= 1'b0;           // Cycle ends on the ack edge
                        wb_stb_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                        wb_sel_o <= '0;
                    end
                end
                WB_ACK: begin
                    wb_state <= WB_IDLE;            // Lines up with OBI_VALID
                end
                default: begin
                    wb_state <= WB_IDLE;
                end
            endcase
        end
    end

    // Address and data registers
    always_ff @(posedge obi_clk_i) begin
        if (accept) begin
            wb_addr_o  <= obi_addr_i[`OBI_ADDR_W-1:2];  // Byte to word address
            wb_wdata_o <= obi_wdata_i;
        end
        if (wb_done) begin
            obi_rdata_o <= wb_we_o ? '0 : wb_rdata_i;   // Writes return zero
        end
    end

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none

`include "bridge_consts.svh"

package wb_pkg;

    typedef logic [`WB_ADDR_W-1:0]      wb_addr_t;  // Word address
    typedef logic [`OBI_DATA_W-1:0]     wb_data_t;  // Data word, same width as OBI
    typedef logic [`OBI_DATA_W/8-1:0]   wb_sel_t;   // Byte select
    typedef logic [`GPIO_W-1:0]         gpio_t;     // GPIO pin vector

    // Wishbone master side of the bridge
    typedef enum logic [1:0] {
        WB_IDLE,    // No cycle on the bus
        WB_AWAIT,   // Cycle open, waiting for ack
        WB_ACK      // Ack taken, response being returned
    } wb_state_e;

    // Target picked by the address decoder
    typedef enum logic [1:0] {
        SLV_SRAM,
        SLV_GPIO,
        SLV_NONE    // Answered by the interconnect itself
    } wb_slave_e;

endpackage

`default_nettype wire

//--- src/obi_pkg.sv
`default_nettype none

`include "bridge_consts.svh"

package obi_pkg;

    typedef logic [`OBI_ADDR_W-1:0]     obi_addr_t;  // Byte address from the master
    typedef logic [`OBI_DATA_W-1:0]     obi_data_t;  // Read and write data word
    typedef logic [`OBI_DATA_W/8-1:0]   obi_be_t;    // One enable per data byte

    // Bridge side of the OBI handshake
    typedef enum logic [1:0] {
        OBI_IDLE,   // Waiting for a request
        OBI_GNT,    // Request granted, Wishbone cycle running
        OBI_AWAIT,  // Still waiting for the slave acknowledge
        OBI_VALID   // Response handed back to the master
    } obi_state_e;

endpackage

`default_nettype wire

//--- src/bridge_consts.svh
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// OBI side is byte addressed with a full 32-bit data word
`define OBI_ADDR_W 32
`define OBI_DATA_W 32

// Wishbone carries word addresses, so the two low byte bits are dropped
`define WB_ADDR_W 30

`define SRAM_DEPTH 16            // Number of 32-bit words in the SRAM
`define SRAM_BASE_WADDR 0        // SRAM starts at word 0
`define GPIO_BASE_WADDR 30'h400  // Byte address 0x1000, OUT at offset 0 and IN at offset 1
`define GPIO_W 8                 // GPIO pin count

`define SRAM_WAIT_DEFAULT 2      // Extra cycles before the SRAM acknowledges

// Read value returned by the interconnect when no slave matches
`define UNMAPPED_RDATA 32'hBAD0_ADD0

`endif
